// File: include/mem_cfg.svh
////////////////////////////////////////////////////////////
// Geometry and bank timing for the cache memory system
// Included by the type package and by RTL that sizes arrays
////////////////////////////////////////////////////////////
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Address split of a byte address: tag, index, word, byte
`define MEM_TAG_W          5
`define MEM_INDEX_W        8
`define MEM_WORDS_PER_LINE 4

// Interleaved main memory
`define MEM_BANKS          4
`define MEM_BANK_BUSY      4
`define MEM_READ_LAT       2

`endif

// File: verilog/mem_types_pkg.sv
////////////////////////////////////////////////////////////
// Width types shared by the cache, the banks and the top
// level; import with a wildcard in the module header
////////////////////////////////////////////////////////////
package mem_types_pkg;

`include "mem_cfg.svh"

   // Host side
   typedef logic [15:0] addr_t;
   typedef logic [15:0] word_t;

   // Fields of a byte address
   typedef logic [`MEM_TAG_W-1:0]   tag_t;
   typedef logic [`MEM_INDEX_W-1:0] index_t;
   // Word within a line, also the bank number
   typedef logic [1:0]              word_sel_t;

   // One busy flag per bank
   typedef logic [`MEM_BANKS-1:0]   bank_mask_t;

endpackage

// File: verilog/cache_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Controller state encoding and cache store operations
////////////////////////////////////////////////////////////
package cache_ctrl_pkg;

   // Request sequencing
   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      EVICT,
      FILL_REQ,
      FILL_WAIT,
      ACCESS,
      FINISH
   } ctrl_state_t;

   // What the store does with the current request
   typedef enum logic [1:0] {
      OP_NONE,
      OP_CMP_RD,
      OP_CMP_WR,
      OP_FILL_WR
   } store_op_t;

endpackage

// File: verilog/mem_ifs.sv
////////////////////////////////////////////////////////////
// Internal links: controller to cache store (cache_if) and
// controller to interleaved bank memory (bank_if)
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface cache_if
   import mem_types_pkg::*, cache_ctrl_pkg::*;
();
   logic      enable;
   store_op_t op;
   tag_t      tag;
   index_t    index;
   word_sel_t word_sel;
   word_t     data_in;
   logic      dirty_in;
   // Combinational results of the addressed line
   logic      hit;
   logic      valid;
   logic      dirty;
   tag_t      tag_out;
   word_t     data_out;

   modport ctrl (output enable, op, tag, index, word_sel, data_in, dirty_in,
                 input  hit, valid, dirty, tag_out, data_out);
   modport store (input  enable, op, tag, index, word_sel, data_in, dirty_in,
                  output hit, valid, dirty, tag_out, data_out);
endinterface

interface bank_if
   import mem_types_pkg::*;
();
   addr_t      addr;
   word_t      wdata;
   logic       wr;
   logic       rd;
   word_t      rdata;
   logic       rvalid;
   logic       stall;
   bank_mask_t busy;

   modport ctrl (output addr, wdata, wr, rd, input rdata, rvalid, stall, busy);
   modport mem (input addr, wdata, wr, rd, output rdata, rvalid, stall, busy);
endinterface

// File: verilog/cache_store.sv
////////////////////////////////////////////////////////////
// Direct-mapped line store: tag, valid, dirty and data
// arrays. Lookups are combinational, writes on the clock
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mem_cfg.svh"

module cache_store
   import mem_types_pkg::*, cache_ctrl_pkg::*;
(
   input logic    clk,
   input logic    rst_n,
   cache_if.store cif
);

   localparam int LINES = 1 << `MEM_INDEX_W;
   localparam word_sel_t LAST_WORD = word_sel_t'(`MEM_WORDS_PER_LINE - 1);

   tag_t              tags [LINES];
   word_t             data [LINES][`MEM_WORDS_PER_LINE];
   logic [LINES-1:0]  valid_q;
   logic [LINES-1:0]  dirty_q;

   logic is_compare;
   logic fill_wr;
   logic word_wr;

   // Addressed line, always visible
   assign cif.tag_out  = tags[cif.index];
   assign cif.valid    = valid_q[cif.index];
   assign cif.dirty    = dirty_q[cif.index];
   assign cif.data_out = data[cif.index][cif.word_sel];

   assign is_compare = (cif.op == OP_CMP_RD) || (cif.op == OP_CMP_WR);
   assign cif.hit    = cif.enable && is_compare && cif.valid && (cif.tag_out == cif.tag);

   assign fill_wr = cif.enable && (cif.op == OP_FILL_WR);
   // Compare-write only lands on a hit
   assign word_wr = fill_wr || (cif.hit && (cif.op == OP_CMP_WR));

   ////////////////////////////////////////////////////////////
   // Line contents
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (word_wr) begin
         data[cif.index][cif.word_sel] <= cif.data_in;
      end
      if (fill_wr) begin
         tags[cif.index] <= cif.tag;
      end
   end

   ////////////////////////////////////////////////////////////
   // Valid and dirty bits
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         if (cif.hit && (cif.op == OP_CMP_WR)) begin
            dirty_q[cif.index] <= 1'b1;
         end
         if (fill_wr) begin
            valid_q[cif.index] <= 1'b1;
            // Dirty state settles once the whole line is in
            if (cif.word_sel == LAST_WORD) begin
               dirty_q[cif.index] <= cif.dirty_in;
            end
         end
      end
   end

endmodule

// File: verilog/bank_mem.sv
////////////////////////////////////////////////////////////
// Word-interleaved main memory of four banks. Address bits
// [2:1] pick the bank; each bank has its own busy window
// and read pipeline, so up to four reads can be in flight
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mem_cfg.svh"

module bank_mem
   import mem_types_pkg::*;
(
   input logic clk,
   input logic rst_n,
   bank_if.mem bif
);

   localparam int ROW_W  = $bits(tag_t) + $bits(index_t);
   localparam int ROWS   = 1 << ROW_W;
   localparam int BUSY_W = $clog2(`MEM_BANK_BUSY + 1);

   // Content starts at zero
   word_t mem [`MEM_BANKS][ROWS] = '{default: '0};

   logic [ROW_W-1:0] row;
   word_sel_t        sel;
   logic             take;
   bank_mask_t       busy_mask;
   bank_mask_t       last_v;
   word_t            last_d [`MEM_BANKS];

   assign row  = bif.addr[15:3];
   assign sel  = bif.addr[2:1];
   assign take = (bif.rd || bif.wr) && !bif.stall;

   assign bif.busy  = busy_mask;
   assign bif.stall = busy_mask[sel];

   always_ff @(posedge clk) begin
      if (take && bif.wr) begin
         mem[sel][row] <= bif.wdata;
      end
   end

   ////////////////////////////////////////////////////////////
   // Per-bank busy counter and read pipeline
   ////////////////////////////////////////////////////////////
   for (genvar b = 0; b < `MEM_BANKS; b++) begin : g_bank
      logic [BUSY_W-1:0]        busy_cnt;
      logic [`MEM_READ_LAT-1:0] pipe_v;
      word_t                    pipe_d [`MEM_READ_LAT];
      logic                     sel_bank;

      assign sel_bank     = take && (sel == b);
      assign busy_mask[b] = (busy_cnt != '0);
      assign last_v[b]    = pipe_v[`MEM_READ_LAT-1];
      assign last_d[b]    = pipe_d[`MEM_READ_LAT-1];

      always_ff @(posedge clk) begin
         if (!rst_n) begin
            busy_cnt <= '0;
            pipe_v   <= '0;
         end else begin
            if (sel_bank) begin
               busy_cnt <= BUSY_W'(`MEM_BANK_BUSY);
            end else if (busy_cnt != '0) begin
               busy_cnt <= busy_cnt - 1'b1;
            end
            pipe_v[0] <= sel_bank && bif.rd;
            for (int i = 1; i < `MEM_READ_LAT; i++) begin
               pipe_v[i] <= pipe_v[i-1];
            end
         end
      end

      // Data rides along with the valid bits
      always_ff @(posedge clk) begin
         pipe_d[0] <= mem[b][row];
         for (int i = 1; i < `MEM_READ_LAT; i++) begin
            pipe_d[i] <= pipe_d[i-1];
         end
      end
   end

   // Reads are taken one per cycle, so at most one bank returns
   always_comb begin
      bif.rvalid = 1'b0;
      bif.rdata  = '0;
      for (int b = 0; b < `MEM_BANKS; b++) begin
         if (last_v[b]) begin
            bif.rvalid = 1'b1;
            bif.rdata  = last_d[b];
         end
      end
   end

endmodule

// File: verilog/cache_ctrl.sv
////////////////////////////////////////////////////////////
// Request sequencer: checks the host request, compares in
// the store, writes back a dirty victim, refills the line
// from the banks and finishes the access from the cache
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mem_cfg.svh"

module cache_ctrl
   import mem_types_pkg::*, cache_ctrl_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  addr_t  addr,
   input  word_t  data_in,
   input  logic   rd,
   input  logic   wr,
   cache_if.ctrl  cif,
   bank_if.ctrl   bif,
   output word_t  data_out,
   output logic   done,
   output logic   stall,
   output logic   cache_hit,
   output logic   err
);

   localparam word_sel_t LAST_WORD = word_sel_t'(`MEM_WORDS_PER_LINE - 1);

   ctrl_state_t state;
   ctrl_state_t next_state;

   addr_t     req_addr;
   word_t     req_data;
   logic      req_wr;
   tag_t      req_tag;
   index_t    req_index;
   word_sel_t req_word;

   word_sel_t cnt;
   word_sel_t fill_cnt;
   logic      hit_q;
   logic      err_q;
   word_t     rdata_q;

   logic ready;
   logic req_take;
   logic illegal;
   logic issued;

   assign {req_tag, req_index, req_word} = req_addr[15:1];

   // A new request may land while done is up
   assign ready    = (state == IDLE) || (state == FINISH);
   assign req_take = ready && (rd || wr);
   assign illegal  = (rd && wr) || addr[0];
   assign issued   = (bif.rd || bif.wr) && !bif.stall;

   assign done      = (state == FINISH);
   assign stall     = !ready;
   assign cache_hit = done && hit_q;
   assign data_out  = rdata_q;
   assign err       = err_q;

   ////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////
   always_comb begin
      next_state = state;
      case (state)
         IDLE, FINISH: next_state = (req_take && !illegal) ? COMPARE : IDLE;
         COMPARE: begin
            if (cif.hit)
               next_state = FINISH;
            else if (cif.valid && cif.dirty)
               next_state = EVICT;
            else
               next_state = FILL_REQ;
         end
         EVICT:     if (issued && cnt == LAST_WORD) next_state = FILL_REQ;
         FILL_REQ:  if (issued && cnt == LAST_WORD) next_state = FILL_WAIT;
         FILL_WAIT: if (bif.rvalid && fill_cnt == LAST_WORD) next_state = ACCESS;
         ACCESS:    next_state = FINISH;
         default:   next_state = IDLE;
      endcase
   end

   // Store port
   always_comb begin
      cif.enable   = 1'b0;
      cif.op       = OP_NONE;
      cif.tag      = req_tag;
      cif.index    = req_index;
      cif.word_sel = req_word;
      cif.data_in  = req_data;
      cif.dirty_in = 1'b0;
      case (state)
         COMPARE, ACCESS: begin
            cif.enable = 1'b1;
            cif.op     = req_wr ? OP_CMP_WR : OP_CMP_RD;
         end
         // Victim word read for the write-back
         EVICT: begin
            cif.enable   = 1'b1;
            cif.word_sel = cnt;
         end
         // A pending write leaves the refilled line dirty
         FILL_REQ, FILL_WAIT: begin
            if (bif.rvalid) begin
               cif.enable   = 1'b1;
               cif.op       = OP_FILL_WR;
               cif.word_sel = fill_cnt;
               cif.data_in  = bif.rdata;
               cif.dirty_in = req_wr;
            end
         end
         default: ;
      endcase
   end

   // Bank port; requests are held back while the bank is busy
   always_comb begin
      bif.addr  = {req_tag, req_index, cnt, 1'b0};
      bif.wdata = cif.data_out;
      bif.wr    = 1'b0;
      bif.rd    = 1'b0;
      if (state == EVICT) begin
         bif.addr = {cif.tag_out, req_index, cnt, 1'b0};
         bif.wr   = !bif.busy[cnt];
      end
      if (state == FILL_REQ) begin
         bif.rd = !bif.busy[cnt];
      end
   end

   ////////////////////////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= IDLE;
         err_q    <= 1'b0;
         hit_q    <= 1'b0;
         cnt      <= '0;
         fill_cnt <= '0;
      end else begin
         state <= next_state;
         err_q <= req_take && illegal;
         if (state == COMPARE) begin
            hit_q    <= cif.hit;
            cnt      <= '0;
            fill_cnt <= '0;
         end else begin
            if (issued) cnt <= cnt + 1'b1;
            if (bif.rvalid) fill_cnt <= fill_cnt + 1'b1;
         end
      end
   end

   // Request and result payload
   always_ff @(posedge clk) begin
      if (req_take && !illegal) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
      if ((state == COMPARE && cif.hit) || state == ACCESS) begin
         rdata_q <= req_wr ? req_data : cif.data_out;
      end
   end

endmodule

// File: verilog/mem_system.sv
////////////////////////////////////////////////////////////
// Cache memory system top: cached word memory for a host
// that issues one read or write and waits for done
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_system
   import mem_types_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  addr_t addr,
   input  word_t data_in,
   input  logic  rd,
   input  logic  wr,
   output word_t data_out,
   output logic  done,
   output logic  stall,
   output logic  cache_hit,
   output logic  err
);

   cache_if cif ();
   bank_if  bif ();

   cache_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .cif       (cif.ctrl),
      .bif       (bif.ctrl),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   // Line store and banks work side by side
   cache_store u_store (
      .clk   (clk),
      .rst_n (rst_n),
      .cif   (cif.store)
   );

   bank_mem u_banks (
      .clk   (clk),
      .rst_n (rst_n),
      .bif   (bif.mem)
   );

endmodule

// File: bench/mem_system_assert.sv
////////////////////////////////////////////////////////////
// Protocol checks on the top-level outputs of the cache
// memory system, bound into mem_system from the testbench
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_system_assert (
   input logic clk,
   input logic rst_n,
   input logic rd,
   input logic wr,
   input logic done,
   input logic stall,
   input logic cache_hit,
   input logic err
);

   logic seen_req;

   // Number of failed properties
   int fail_count = 0;

   // Set once the host has made any request since reset
   always @(posedge clk) begin
      if (!rst_n) begin
         seen_req <= 1'b0;
      end else if (rd || wr) begin
         seen_req <= 1'b1;
      end
   end

   a_done_stall : assert property (@(posedge clk) disable iff (!rst_n)
      !(done && stall))
      else begin
         $error("done and stall high together");
         fail_count++;
      end

   a_hit_with_done : assert property (@(posedge clk) disable iff (!rst_n)
      cache_hit |-> done)
      else begin
         $error("cache_hit high without done");
         fail_count++;
      end

   a_err_done : assert property (@(posedge clk) disable iff (!rst_n)
      !(err && done))
      else begin
         $error("err and done high together");
         fail_count++;
      end

   // Quiet outputs between reset and the first request
   a_quiet_after_reset : assert property (@(posedge clk) disable iff (!rst_n)
      !seen_req |-> !(done || stall || cache_hit || err))
      else begin
         $error("output high before the first request");
         fail_count++;
      end

endmodule

bind mem_system mem_system_assert u_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .rd        (rd),
   .wr        (wr),
   .done      (done),
   .stall     (stall),
   .cache_hit (cache_hit),
   .err       (err)
);

// File: bench/mem_system_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the cache memory system: directed and random
// reads and writes against a shadow memory and tag model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_system_tb
   import mem_types_pkg::*;
();

   localparam int N_DIRECTED  = 9;
   localparam int N_RANDOM    = 300;
   localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM) * 40 + 200;
   localparam int LINES       = 1 << `MEM_INDEX_W;
   localparam int MEM_WORDS   = 1 << 15;
   localparam int K_READ      = 0;
   localparam int K_WRITE     = 1;
   localparam int K_ILLEGAL   = 2;

   logic  clk;
   logic  rst_n;
   addr_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   // Shadow state of memory and cache tags
   word_t shadow_mem [MEM_WORDS];
   tag_t  ref_tag [LINES];
   logic  ref_valid [LINES];

   // Pending results, oldest first
   string exp_name [$];
   int    exp_kind [$];
   word_t exp_word [$];
   logic  exp_hit [$];

   integer seed;
   int     cycle_count = 0;

   mem_system UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Failure handling and compare tasks
   ////////////////////////////////////////////////////////////
   task automatic stop_run();
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic fail_plain(input string msg);
      $display("%s", msg);
      stop_run();
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_hit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s: cache_hit expected %b, actual %b", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s: err expected %b, actual %b", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_stall(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s: stall expected %b, actual %b", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_cycles(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("ERR %s: result after %0d cycles expected, actual %0d", name, exp, act);
         stop_run();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////
   function automatic addr_t make_addr(input tag_t t, input index_t ix, input word_sel_t w);
      return {t, ix, w, 1'b0};
   endfunction

   // Expected {cache_hit, read data} before the access
   function automatic logic [16:0] predict(input addr_t a);
      tag_t      t;
      index_t    ix;
      word_sel_t w;
      logic      hit;
      {t, ix, w} = a[15:1];
      hit = ref_valid[ix] && (ref_tag[ix] == t);
      return {hit, shadow_mem[a[15:1]]};
   endfunction

   task automatic update_model(input addr_t a, input logic is_wr, input word_t d);
      tag_t      t;
      index_t    ix;
      word_sel_t w;
      {t, ix, w} = a[15:1];
      ref_valid[ix] = 1'b1;
      ref_tag[ix]   = t;
      if (is_wr) begin
         shadow_mem[a[15:1]] = d;
      end
   endtask

   // One host request; returns once done or err shows up
   task automatic run_op(input string name, input logic r, input logic w,
                         input addr_t a, input word_t d);
      logic [16:0] pred;
      logic        legal;
      int          waited;
      pred  = predict(a);
      legal = !(r && w) && !a[0];
      @(negedge clk);
      while (stall) @(negedge clk);
      addr    = a;
      data_in = d;
      rd      = r;
      wr      = w;
      exp_name.push_back(name);
      exp_kind.push_back(!legal ? K_ILLEGAL : (w ? K_WRITE : K_READ));
      exp_word.push_back(pred[15:0]);
      exp_hit.push_back(pred[16]);
      if (legal) begin
         update_model(a, w, d);
      end
      @(negedge clk);
      rd     = 1'b0;
      wr     = 1'b0;
      waited = 1;
      while (!done && !err) begin
         // Busy from the cycle after the request until done
         check_stall(name, 1'b1, stall);
         @(negedge clk);
         waited++;
      end
      if (!legal) begin
         check_cycles(name, 1, waited);
         check_stall(name, 1'b0, stall);
         // Any late done now finds no pending request
         repeat (2) @(negedge clk);
      end else if (pred[16]) begin
         check_cycles(name, 2, waited);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Result compare and cycle limit
   ////////////////////////////////////////////////////////////
   always @(negedge clk) begin : compare_results
      string nm;
      int    kind;
      word_t word;
      logic  hit;
      if (rst_n && (done || err)) begin
         if (exp_kind.size() == 0) begin
            fail_plain("done or err came with no request pending");
         end else begin
            nm   = exp_name.pop_front();
            kind = exp_kind.pop_front();
            word = exp_word.pop_front();
            hit  = exp_hit.pop_front();
            if (kind == K_ILLEGAL) begin
               check_err(nm, 1'b1, err);
               if (done) begin
                  fail_plain({nm, ": done was raised for an illegal request"});
               end
            end else begin
               check_err(nm, 1'b0, err);
               check_hit(nm, hit, cache_hit);
               if (kind == K_READ) begin
                  check_word(nm, word, data_out);
               end
            end
         end
      end
   end

   always @(negedge clk) begin
      if (UUT.u_assert.fail_count != 0) begin
         fail_plain("a protocol assertion on the DUT outputs failed");
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         fail_plain("timeout: the tests did not finish within the cycle limit");
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////
   initial begin : stimulus
      int        i;
      tag_t      t;
      index_t    ix;
      word_sel_t w;
      addr_t     a_addr;
      addr_t     b_addr;
      logic      r;
      word_t     d;
      seed    = 26018;
      clk     = 1'b0;
      rst_n   = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      for (i = 0; i < MEM_WORDS; i++) begin
         shadow_mem[i] = '0;
      end
      for (i = 0; i < LINES; i++) begin
         ref_valid[i] = 1'b0;
         ref_tag[i]   = '0;
      end
      repeat (5) @(negedge clk);
      rst_n = 1'b1;

      run_op("cold read", 1'b1, 1'b0, make_addr(3, 9, 1), '0);

      // Second access to the same word must hit in two cycles
      a_addr = make_addr(4, 17, 2);
      run_op("write then read: write", 1'b0, 1'b1, a_addr, 16'h5a3c);
      run_op("write then read: read", 1'b1, 1'b0, a_addr, '0);

      // Same index, other tag: dirty A goes back to the banks
      a_addr = make_addr(1, 5, 2);
      b_addr = make_addr(2, 5, 2);
      run_op("conflict: write A", 1'b0, 1'b1, a_addr, 16'h1111);
      run_op("conflict: write B", 1'b0, 1'b1, b_addr, 16'h2222);
      run_op("conflict: read A", 1'b1, 1'b0, a_addr, '0);

      run_op("illegal: rd and wr", 1'b1, 1'b1, a_addr, 16'hdead);
      run_op("illegal: odd address", 1'b0, 1'b1, a_addr | 16'h1, 16'hbeef);
      run_op("illegal: read back", 1'b1, 1'b0, a_addr, '0);

      // Few tags and lines, so hits, conflicts and evictions mix
      for (i = 0; i < N_RANDOM; i++) begin
         t  = tag_t'($random(seed) & 3);
         ix = index_t'($random(seed) & 3);
         w  = word_sel_t'($random(seed));
         r  = logic'($random(seed) & 1);
         d  = word_t'($random(seed));
         run_op($sformatf("random %0d", i), r, !r, make_addr(t, ix, w), d);
      end

      repeat (2) @(negedge clk);
      if (exp_kind.size() != 0) begin
         fail_plain("a request ended without done or err");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

// File: sources.f
+incdir+include
verilog/mem_types_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/mem_ifs.sv
verilog/cache_store.sv
verilog/bank_mem.sv
verilog/cache_ctrl.sv
verilog/mem_system.sv
bench/mem_system_assert.sv
bench/mem_system_tb.sv
